// File: rtl/fpFormatPkg.sv
// ==============================
// floating-point format types
// binary64 and binary32 layouts, the buffer word and exponent constants
// ==============================
`default_nettype none

package fpFormatPkg;

  // binary64 as sign, biased exponent, fraction
  typedef struct packed {
    logic        sign;
    logic [10:0] exp;
    logic [51:0] man;
  } f64_t;

  // binary32 as sign, biased exponent, fraction
  typedef struct packed {
    logic        sign;
    logic [7:0]  exp;
    logic [22:0] man;
  } f32_t;

  // two binary32 values side by side in one 64-bit word
  typedef struct packed {
    f32_t hi;
    f32_t lo;
  } f32Pair_t;

  // buffer word, one double or two singles
  typedef union packed {
    f64_t     f64;
    f32Pair_t f32;
  } fpWord_u;

  // decomposer flags
  typedef struct packed {
    logic xinf;
    logic xz;
    logic vz;
  } fpClass_t;

  localparam int BIAS64 = 1023;
  localparam int BIAS32 = 127;
  // difference of the two biases
  localparam int REBIAS = BIAS64 - BIAS32;
  // smallest and largest binary64 exponents that still land on a normal binary32
  localparam int NARROW_MIN_EXP = REBIAS + 1;
  localparam int NARROW_MAX_EXP = REBIAS + 254;

endpackage

`default_nettype wire

// File: rtl/fpCvtRegPkg.sv
// ==============================
// converter register map
// command, status and AXI4-Lite channel structs
// ==============================
`default_nettype none

package fpCvtRegPkg;

  localparam int BUF_DEPTH = 8;

  typedef logic [$clog2(BUF_DEPTH)-1:0] idx_t;

  // byte addresses, entry i has lo at ADDR_BUF+8i and hi at ADDR_BUF+8i+4
  localparam logic [7:0] ADDR_CTRL   = 8'h00;
  localparam logic [7:0] ADDR_STATUS = 8'h04;
  localparam logic [7:0] ADDR_BUF    = 8'h40;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // mode 0 narrows, mode 1 widens
  typedef struct packed {
    logic start;
    logic mode;
    idx_t lastIdx;
  } cvtCmd_t;

  typedef struct packed {
    logic busy;
    logic done;
  } cvtStatus_t;

  // master to slave
  typedef struct packed {
    logic        awvalid;
    logic [7:0]  awaddr;
    logic        wvalid;
    logic [31:0] wdata;
    logic        bready;
    logic        arvalid;
    logic [7:0]  araddr;
    logic        rready;
  } axilReq_t;

  // slave to master
  typedef struct packed {
    logic        awready;
    logic        wready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
  } axilRsp_t;

endpackage

`default_nettype wire

// File: rtl/fpDecomp.sv
// ==============================
// float field classifier
// flags inf/nan exponent, zero exponent and zero value
// ==============================
`timescale 1ns/10ps
`default_nettype none

module fpDecomp #(
  parameter int WIDTH = 64
) (
  input  wire logic [WIDTH-1:0] i,
  output fpFormatPkg::fpClass_t cls
);
  import fpFormatPkg::*;

  // field layout follows from the word width
  if (WIDTH == 64) begin : gen64
    f64_t v;

    assign v = f64_t'(i);
    // all-ones exponent is inf or nan
    assign cls.xinf = &v.exp;
    // zero exponent is zero or subnormal
    assign cls.xz = ~|v.exp;
    // sign ignored so -0 counts as zero
    assign cls.vz = ~|{v.exp, v.man};
  end else begin : gen32
    f32_t v;

    assign v = f32_t'(i);
    assign cls.xinf = &v.exp;
    assign cls.xz = ~|v.exp;
    assign cls.vz = ~|{v.exp, v.man};
  end

endmodule

`default_nettype wire

// File: rtl/f64ToF32.sv
// ==============================
// binary64 to binary32 narrowing
// truncates the fraction, flushes and saturates out-of-range values
// ==============================
`timescale 1ns/10ps
`default_nettype none

module f64ToF32 (
  input  wire fpFormatPkg::f64_t a,
  output fpFormatPkg::f32_t      o
);
  import fpFormatPkg::*;

  fpClass_t cls;

  fpDecomp #(.WIDTH(64)) u_fpDecomp (
    .i  (a),
    .cls(cls)
  );

  always_comb begin
    o = '0;
    // sign passes straight through in every case
    o.sign = a.sign;
    if (cls.vz) begin
      // signed zero, already cleared
    end else if (cls.xinf) begin
      // inf keeps a zero fraction, nan keeps its top payload bits
      o.exp = '1;
      o.man = a.man[51:29];
      // quiet bit so a low-only payload never turns into inf
      if (a.man != '0)
        o.man[22] = 1'b1;
    end else if (cls.xz) begin
      // binary64 subnormals are far below binary32 range
    end else if (a.exp < 11'(NARROW_MIN_EXP)) begin
      // underflow flushes to zero
    end else if (a.exp > 11'(NARROW_MAX_EXP)) begin
      // overflow saturates to inf
      o.exp = '1;
    end else begin
      o.exp = 8'(a.exp - 11'(REBIAS));
      o.man = a.man[51:29];
    end
  end

  // nan in must leave as nan, decomposer and datapath together
  always_comb begin
    if (&a.exp && a.man != '0)
      assert final (&o.exp && o.man != '0)
        else $error("narrowed nan came out as %h", o);
  end

endmodule

`default_nettype wire

// File: rtl/f32ToF64.sv
// ==============================
// binary32 to binary64 widening
// exact, subnormals are renormalized
// ==============================
`timescale 1ns/10ps
`default_nettype none

module f32ToF64 (
  input  wire fpFormatPkg::f32_t a,
  output fpFormatPkg::f64_t      o
);
  import fpFormatPkg::*;

  fpClass_t    cls;
  logic [4:0]  lz;
  logic [4:0]  k;
  logic [22:0] manSh;

  fpDecomp #(.WIDTH(32)) u_fpDecomp (
    .i  (a),
    .cls(cls)
  );

  // leading zeros of the fraction
  // ascending scan so the highest set bit wins
  always_comb begin
    lz = 5'd23;
    for (int b = 0; b < $bits(a.man); b++) begin
      if (a.man[b])
        lz = 5'(22 - b);
    end
  end

  // shift the leading one out, it becomes the hidden bit
  assign k     = lz + 5'd1;
  assign manSh = a.man << k;

  always_comb begin
    o = '0;
    o.sign = a.sign;
    if (cls.vz) begin
      // signed zero
    end else if (cls.xinf) begin
      o.exp = '1;
      o.man = {a.man, 29'd0};
      // nan stays quiet, inf keeps zero fraction
      if (a.man != '0)
        o.man[51] = 1'b1;
    end else if (cls.xz) begin
      // 0.m x 2^-126 rewritten as 1.f x 2^(-126-k)
      o.exp = 11'(NARROW_MIN_EXP) - 11'(k);
      o.man = {manSh, 29'd0};
    end else begin
      o.exp = 11'(a.exp) + 11'(REBIAS);
      o.man = {a.man, 29'd0};
    end
  end

endmodule

`default_nettype wire

// File: rtl/fpCvtIndex.sv
// ==============================
// batch entry index counter
// ==============================
`timescale 1ns/10ps
`default_nettype none

module fpCvtIndex (
  input  wire                     clk,
  input  wire                     arstN,
  input  wire                     load,
  input  wire fpCvtRegPkg::idx_t  lastIdx,
  input  wire                     step,
  output fpCvtRegPkg::idx_t       idx,
  output logic                    last
);
  import fpCvtRegPkg::*;

  // end index captured at load
  idx_t endQ;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      idx  <= '0;
      endQ <= '0;
    end else if (load) begin
      idx  <= '0;
      endQ <= lastIdx;
    end else if (step) begin
      idx <= idx + 1'b1;
    end
  end

  assign last = idx == endQ;

  // the sequencer must stop stepping on the final entry
  aNoStepPastEnd: assert property (@(posedge clk) disable iff (!arstN)
    !(step && idx == endQ));

endmodule

`default_nettype wire

// File: rtl/fpCvtSeq.sv
// ==============================
// batch conversion sequencer
// IDLE/RUN/FIN FSM with sticky done flag
// ==============================
`timescale 1ns/10ps
`default_nettype none

module fpCvtSeq (
  input  wire                         clk,
  input  wire                         arstN,
  input  wire fpCvtRegPkg::cvtCmd_t   cmd,
  input  wire                         doneClr,
  input  wire fpCvtRegPkg::idx_t      idx,
  input  wire                         last,
  output fpCvtRegPkg::cvtStatus_t     status,
  output logic                        load,
  output logic                        step,
  output logic                        cvtWe,
  output logic                        mode
);
  import fpCvtRegPkg::*;

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    FIN
  } seqState_t;

  seqState_t state;
  logic      done;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= IDLE;
      mode  <= 1'b0;
      done  <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (cmd.start) begin
            state <= RUN;
            // direction held for the whole batch
            mode  <= cmd.mode;
          end
        end
        // one entry per cycle until the counter flags the end
        RUN:     if (last) state <= FIN;
        FIN:     state <= IDLE;
        default: state <= IDLE;
      endcase
      // set on leaving FIN, cleared by software or by a new start
      if (state == FIN)
        done <= 1'b1;
      else if (doneClr || (state == IDLE && cmd.start))
        done <= 1'b0;
    end
  end

  // ==============================
  // outputs
  // ==============================
  assign load   = state == IDLE && cmd.start;
  assign cvtWe  = state == RUN;
  assign step   = state == RUN && !last;
  assign status = '{busy: state != IDLE, done: done};

  // first write of a batch lands on entry 0
  aRunFromZero: assert property (@(posedge clk) disable iff (!arstN)
    load |=> cvtWe && idx == '0);

  // each step moves the write-back on to the next entry
  aIdxAdvance: assert property (@(posedge clk) disable iff (!arstN)
    step |=> idx == idx_t'($past(idx) + 1'b1));

endmodule

`default_nettype wire

// File: rtl/fpCvtBuffer.sv
// ==============================
// eight-entry conversion buffer
// bus port plus in-place write-back from the converters
// ==============================
`timescale 1ns/10ps
`default_nettype none

module fpCvtBuffer (
  input  wire                    clk,
  input  wire                    arstN,
  input  wire                    busWe,
  input  wire fpCvtRegPkg::idx_t busIdx,
  input  wire                    busHalf,
  input  wire [31:0]             busData,
  input  wire fpCvtRegPkg::idx_t busRdIdx,
  input  wire                    busRdHalf,
  input  wire                    cvtWe,
  input  wire fpCvtRegPkg::idx_t idx,
  input  wire                    mode,
  output logic [31:0]            busRdData
);
  import fpFormatPkg::*;
  import fpCvtRegPkg::*;

  fpWord_u mem [BUF_DEPTH];
  fpWord_u cur;
  fpWord_u cvtWord;
  f32_t    narrowed;
  f64_t    widened;

  // both views of the current entry feed the converters
  assign cur = mem[idx];

  f64ToF32 u_f64ToF32 (
    .a(cur.f64),
    .o(narrowed)
  );

  f32ToF64 u_f32ToF64 (
    .a(cur.f32.lo),
    .o(widened)
  );

  // narrowed result goes low with the high half zeroed
  always_comb begin
    if (mode) begin
      cvtWord.f64 = widened;
    end else begin
      cvtWord.f32.hi = '0;
      cvtWord.f32.lo = narrowed;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int e = 0; e < BUF_DEPTH; e++)
        mem[e] <= '0;
    end else if (cvtWe) begin
      mem[idx] <= cvtWord;
    end else if (busWe) begin
      if (busHalf)
        mem[busIdx].f32.hi <= f32_t'(busData);
      else
        mem[busIdx].f32.lo <= f32_t'(busData);
    end
  end

  assign busRdData = busRdHalf ? mem[busRdIdx].f32.hi : mem[busRdIdx].f32.lo;

endmodule

`default_nettype wire

// File: rtl/fpCvtAxil.sv
// ==============================
// AXI4-Lite register slave
// CTRL, STATUS and the buffer window
// ==============================
`timescale 1ns/10ps
`default_nettype none

module fpCvtAxil (
  input  wire                          clk,
  input  wire                          arstN,
  input  wire fpCvtRegPkg::axilReq_t   axilReq,
  input  wire fpCvtRegPkg::cvtStatus_t status,
  input  wire [31:0]                   busRdData,
  output fpCvtRegPkg::axilRsp_t        axilRsp,
  output fpCvtRegPkg::cvtCmd_t         cmd,
  output logic                         doneClr,
  output logic                         busWe,
  output fpCvtRegPkg::idx_t            busIdx,
  output logic                         busHalf,
  output logic [31:0]                  busData,
  output fpCvtRegPkg::idx_t            busRdIdx,
  output logic                         busRdHalf
);
  import fpCvtRegPkg::*;

  logic        wrAcc;
  logic        bvalid;
  logic [1:0]  bresp;
  logic        arAcc;
  logic        rvalid;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  // last accepted mode and lastIdx, for readback
  logic [3:0]  ctrlQ;
  logic        wrCtrl;
  logic        wrStat;
  logic        wrBuf;
  logic        wrErr;
  logic        rdBuf;
  logic        rdErr;
  logic [31:0] rdMux;

  // ==============================
  // write decode
  // ==============================
  assign wrCtrl = axilReq.awaddr == ADDR_CTRL;
  assign wrStat = axilReq.awaddr == ADDR_STATUS;
  assign wrBuf  = axilReq.awaddr[7:6] == ADDR_BUF[7:6] && axilReq.awaddr[1:0] == 2'b00;
  // unmapped, or buffer/CTRL touched mid-batch
  assign wrErr  = !(wrCtrl || wrStat || wrBuf) || (status.busy && (wrCtrl || wrBuf));

  // side effects fire in the handshake cycle
  assign busWe   = wrAcc && wrBuf && !status.busy;
  assign busIdx  = idx_t'(axilReq.awaddr[5:3]);
  assign busHalf = axilReq.awaddr[2];
  assign busData = axilReq.wdata;
  assign doneClr = wrAcc && wrStat && axilReq.wdata[0];
  // wdata[3] mode, wdata[2:0] lastIdx
  assign cmd = '{start:   wrAcc && wrCtrl && !status.busy,
                 mode:    axilReq.wdata[3],
                 lastIdx: idx_t'(axilReq.wdata[2:0])};

  // ==============================
  // read decode
  // ==============================
  assign rdBuf     = axilReq.araddr[7:6] == ADDR_BUF[7:6] && axilReq.araddr[1:0] == 2'b00;
  assign busRdIdx  = idx_t'(axilReq.araddr[5:3]);
  assign busRdHalf = axilReq.araddr[2];

  always_comb begin
    rdErr = 1'b0;
    rdMux = '0;
    if (axilReq.araddr == ADDR_CTRL)
      rdMux = {28'd0, ctrlQ};
    else if (axilReq.araddr == ADDR_STATUS)
      rdMux = {30'd0, status};
    else if (rdBuf)
      rdMux = busRdData;
    else
      rdErr = 1'b1;
  end

  // ==============================
  // channel handshakes
  // ==============================
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wrAcc  <= 1'b0;
      bvalid <= 1'b0;
      arAcc  <= 1'b0;
      rvalid <= 1'b0;
      ctrlQ  <= '0;
    end else begin
      // aw and w taken together, response next cycle
      if (bvalid) begin
        if (axilReq.bready)
          bvalid <= 1'b0;
      end else if (wrAcc) begin
        wrAcc  <= 1'b0;
        bvalid <= 1'b1;
      end else if (axilReq.awvalid && axilReq.wvalid) begin
        wrAcc <= 1'b1;
      end
      // read side mirrors it
      if (rvalid) begin
        if (axilReq.rready)
          rvalid <= 1'b0;
      end else if (arAcc) begin
        arAcc  <= 1'b0;
        rvalid <= 1'b1;
      end else if (axilReq.arvalid) begin
        arAcc <= 1'b1;
      end
      if (cmd.start)
        ctrlQ <= {cmd.mode, cmd.lastIdx};
    end
  end

  // response payload captured at handshake
  always_ff @(posedge clk) begin
    if (wrAcc)
      bresp <= wrErr ? RESP_SLVERR : RESP_OKAY;
    if (arAcc) begin
      rdata <= rdMux;
      rresp <= rdErr ? RESP_SLVERR : RESP_OKAY;
    end
  end

  assign axilRsp = '{awready: wrAcc, wready: wrAcc, bvalid: bvalid, bresp: bresp,
                     arready: arAcc, rvalid: rvalid, rdata: rdata, rresp: rresp};

  // a pending write response is never withdrawn or changed
  aBvalidHold: assert property (@(posedge clk) disable iff (!arstN)
    axilRsp.bvalid && !axilReq.bready |=> axilRsp.bvalid && $stable(axilRsp.bresp));

endmodule

`default_nettype wire

// File: rtl/fpCvtTop.sv
// ==============================
// float format converter top
// bus slave, sequencer, index counter and buffer
// ==============================
`timescale 1ns/10ps
`default_nettype none

module fpCvtTop (
  input  wire                        clk,
  input  wire                        arstN,
  input  wire fpCvtRegPkg::axilReq_t axilReq,
  output fpCvtRegPkg::axilRsp_t      axilRsp,
  output logic                       irq
);
  import fpCvtRegPkg::*;

  cvtCmd_t     cmd;
  cvtStatus_t  status;
  logic        doneClr;
  logic        busWe;
  idx_t        busIdx;
  logic        busHalf;
  logic [31:0] busData;
  idx_t        busRdIdx;
  logic        busRdHalf;
  logic [31:0] busRdData;
  logic        load;
  logic        step;
  logic        cvtWe;
  logic        mode;
  idx_t        idx;
  logic        last;

  fpCvtAxil u_fpCvtAxil (
    .clk      (clk),
    .arstN    (arstN),
    .axilReq  (axilReq),
    .status   (status),
    .busRdData(busRdData),
    .axilRsp  (axilRsp),
    .cmd      (cmd),
    .doneClr  (doneClr),
    .busWe    (busWe),
    .busIdx   (busIdx),
    .busHalf  (busHalf),
    .busData  (busData),
    .busRdIdx (busRdIdx),
    .busRdHalf(busRdHalf)
  );

  fpCvtSeq u_fpCvtSeq (
    .clk    (clk),
    .arstN  (arstN),
    .cmd    (cmd),
    .doneClr(doneClr),
    .idx    (idx),
    .last   (last),
    .status (status),
    .load   (load),
    .step   (step),
    .cvtWe  (cvtWe),
    .mode   (mode)
  );

  // end index comes straight from the command
  fpCvtIndex u_fpCvtIndex (
    .clk    (clk),
    .arstN  (arstN),
    .load   (load),
    .lastIdx(cmd.lastIdx),
    .step   (step),
    .idx    (idx),
    .last   (last)
  );

  fpCvtBuffer u_fpCvtBuffer (
    .clk      (clk),
    .arstN    (arstN),
    .busWe    (busWe),
    .busIdx   (busIdx),
    .busHalf  (busHalf),
    .busData  (busData),
    .busRdIdx (busRdIdx),
    .busRdHalf(busRdHalf),
    .cvtWe    (cvtWe),
    .idx      (idx),
    .mode     (mode),
    .busRdData(busRdData)
  );

  // interrupt level tracks the sticky done flag
  assign irq = status.done;

endmodule

`default_nettype wire

// File: include/fpCvtTbTasks.svh
// ==============================
// converter testbench bus tasks
// AXI4-Lite master driver and typed compares
// ==============================
`ifndef FP_CVT_TB_TASKS_SVH
`define FP_CVT_TB_TASKS_SVH

// ==============================
// bus driver
// ==============================
// aw and w raised together, held through the ready cycle
task automatic axilWrite(input logic [7:0] addr, input logic [31:0] data,
                         output logic [1:0] resp);
  axilReq.awvalid = 1'b1;
  axilReq.awaddr  = addr;
  axilReq.wvalid  = 1'b1;
  axilReq.wdata   = data;
  @(posedge clk);
  #1;
  while (!axilRsp.awready) begin
    @(posedge clk);
    #1;
  end
  // handshake completes on this edge
  @(posedge clk);
  #1;
  axilReq.awvalid = 1'b0;
  axilReq.wvalid  = 1'b0;
  axilReq.bready  = 1'b1;
  while (!axilRsp.bvalid) begin
    @(posedge clk);
    #1;
  end
  resp = axilRsp.bresp;
  @(posedge clk);
  #1;
  axilReq.bready = 1'b0;
endtask

task automatic axilRead(input logic [7:0] addr, output logic [31:0] data,
                        output logic [1:0] resp);
  axilReq.arvalid = 1'b1;
  axilReq.araddr  = addr;
  @(posedge clk);
  #1;
  while (!axilRsp.arready) begin
    @(posedge clk);
    #1;
  end
  @(posedge clk);
  #1;
  axilReq.arvalid = 1'b0;
  axilReq.rready  = 1'b1;
  while (!axilRsp.rvalid) begin
    @(posedge clk);
    #1;
  end
  data = axilRsp.rdata;
  resp = axilRsp.rresp;
  @(posedge clk);
  #1;
  axilReq.rready = 1'b0;
endtask

// ==============================
// typed compares
// ==============================
task automatic checkWord(input string name, input fpWord_u got, input fpWord_u exp);
  if (got !== exp)
    failRun($sformatf("Error at %0t: %s is %h, expected %h", $time, name, got, exp));
endtask

task automatic checkResp(input string name, input logic [1:0] got, input logic [1:0] exp);
  if (got !== exp)
    failRun($sformatf("Error at %0t: %s is %b, expected %b", $time, name, got, exp));
endtask

task automatic checkStatus(input string name, input cvtStatus_t got, input cvtStatus_t exp);
  if (got !== exp)
    failRun($sformatf("Error at %0t: %s is %b, expected %b", $time, name, got, exp));
endtask

task automatic checkData(input string name, input logic [31:0] got, input logic [31:0] exp);
  if (got !== exp)
    failRun($sformatf("Error at %0t: %s is %h, expected %h", $time, name, got, exp));
endtask

task automatic checkFlag(input string name, input logic got, input logic exp);
  if (got !== exp)
    failRun($sformatf("Error at %0t: %s is %b, expected %b", $time, name, got, exp));
endtask

// ==============================
// register helpers
// ==============================
task automatic writeOk(input logic [7:0] addr, input logic [31:0] data);
  logic [1:0] resp;
  axilWrite(addr, data, resp);
  checkResp($sformatf("bresp @%h", addr), resp, RESP_OKAY);
endtask

task automatic readOk(input logic [7:0] addr, output logic [31:0] data);
  logic [1:0] resp;
  axilRead(addr, data, resp);
  checkResp($sformatf("rresp @%h", addr), resp, RESP_OKAY);
endtask

task automatic readStatus(output cvtStatus_t st);
  logic [31:0] data;
  readOk(ADDR_STATUS, data);
  st = cvtStatus_t'(data[1:0]);
endtask

// poll STATUS until done is set, bounded number of reads
task automatic pollDone();
  logic [31:0] data;
  int          polls;
  polls = 0;
  data  = '0;
  while (!data[0]) begin
    if (polls == 64)
      failRun("conversion never reported done on STATUS");
    readOk(ADDR_STATUS, data);
    polls++;
  end
endtask

`endif

// File: tb/fpCvtTb.sv
// ==============================
// float converter testbench
// directed and random batches over AXI4-Lite
// ==============================
`timescale 1ns/10ps
`default_nettype none

module fpCvtTb;
  import fpFormatPkg::*;
  import fpCvtRegPkg::*;

  localparam int SEED = 32'h2a59;
  // about 40 bus operations per batch, 20 batches plus reset and error checks
  localparam int BUS_OPS        = 20 * 40 + 40;
  localparam int TIMEOUT_CYCLES = BUS_OPS * 40 + 200;

  logic        clk;
  logic        arstN;
  axilReq_t    axilReq;
  axilRsp_t    axilRsp;
  logic        irq;
  fpWord_u     stim [BUF_DEPTH];
  int unsigned seedDummy;

  fpCvtTop u_fpCvtTop (
    .clk    (clk),
    .arstN  (arstN),
    .axilReq(axilReq),
    .axilRsp(axilRsp),
    .irq    (irq)
  );

  always #5 clk = ~clk;

  // report and stop at the first error
  task automatic failRun(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1);
  endtask

  `include "fpCvtTbTasks.svh"

  // ==============================
  // reference model
  // ==============================
  function automatic f32_t refNarrow(input f64_t a);
    f32_t r;
    int   e;
    r      = '0;
    r.sign = a.sign;
    e      = a.exp;
    if (e == 2047) begin
      r.exp = 8'hFF;
      // nan payload keeps its top bits, quiet bit set
      if (a.man != '0)
        r.man = {1'b1, a.man[50:29]};
    end else if (e >= 897 && e <= 1150) begin
      r.exp = 8'(e - 896);
      r.man = a.man[51:29];
    end else if (e > 1150) begin
      r.exp = 8'hFF;
    end
    // zero, subnormal and underflow all stay signed zero
    return r;
  endfunction

  function automatic f64_t refWiden(input f32_t a);
    f64_t        r;
    logic [22:0] m;
    int          k;
    r      = '0;
    r.sign = a.sign;
    if (a.exp == 8'hFF) begin
      r.exp = 11'h7FF;
      if (a.man != '0)
        r.man = {1'b1, a.man[21:0], 29'd0};
    end else if (a.exp == 8'h00 && a.man != '0) begin
      // walk up to the leading one, then drop it as the hidden bit
      m = a.man;
      k = 1;
      while (!m[22]) begin
        m = m << 1;
        k++;
      end
      m     = m << 1;
      r.exp = 11'(897 - k);
      r.man = {m, 29'd0};
    end else if (a.exp != 8'h00) begin
      r.exp = 11'(a.exp) + 11'd896;
      r.man = {a.man, 29'd0};
    end
    return r;
  endfunction

  function automatic fpWord_u expectWord(input fpWord_u in, input logic mode);
    fpWord_u res;
    res = '0;
    if (mode)
      res.f64 = refWiden(in.f32.lo);
    else
      res.f32.lo = refNarrow(in.f64);
    return res;
  endfunction

  function automatic fpWord_u mk64(input logic s, input int e, input logic [51:0] m);
    fpWord_u w;
    w.f64.sign = s;
    w.f64.exp  = 11'(e);
    w.f64.man  = m;
    return w;
  endfunction

  // high half is junk, widening must ignore it
  function automatic fpWord_u mk32(input logic [31:0] lo);
    fpWord_u w;
    w.f32.hi = f32_t'($urandom);
    w.f32.lo = f32_t'(lo);
    return w;
  endfunction

  // ==============================
  // batch helpers
  // ==============================
  task automatic writeWord(input int e, input fpWord_u w);
    writeOk(8'(ADDR_BUF + 8 * e), w.f32.lo);
    writeOk(8'(ADDR_BUF + 8 * e + 4), w.f32.hi);
  endtask

  task automatic readWord(input int e, output fpWord_u w);
    logic [31:0] d;
    readOk(8'(ADDR_BUF + 8 * e), d);
    w.f32.lo = f32_t'(d);
    readOk(8'(ADDR_BUF + 8 * e + 4), d);
    w.f32.hi = f32_t'(d);
  endtask

  // entries below count converted, the rest untouched
  task automatic checkEntries(input logic mode, input int count);
    fpWord_u got;
    for (int e = 0; e < BUF_DEPTH; e++) begin
      readWord(e, got);
      if (e < count)
        checkWord($sformatf("buffer[%0d]", e), got, expectWord(stim[e], mode));
      else
        checkWord($sformatf("buffer[%0d]", e), got, stim[e]);
    end
  endtask

  task automatic finishBatch(input logic mode, input int count);
    cvtStatus_t st;
    cvtStatus_t expSt;
    pollDone();
    readStatus(st);
    expSt.busy = 1'b0;
    expSt.done = 1'b1;
    checkStatus("STATUS after batch", st, expSt);
    checkFlag("irq", irq, 1'b1);
    checkEntries(mode, count);
    // write 1 to done clears it and the interrupt
    writeOk(ADDR_STATUS, 32'h1);
    readStatus(st);
    checkStatus("STATUS after clear", st, cvtStatus_t'(2'b00));
    checkFlag("irq", irq, 1'b0);
  endtask

  task automatic runBatch(input logic mode, input int count);
    for (int e = 0; e < BUF_DEPTH; e++)
      writeWord(e, stim[e]);
    writeOk(ADDR_CTRL, {28'd0, mode, 3'(count - 1)});
    finishBatch(mode, count);
  endtask

  // ==============================
  // directed tests
  // ==============================
  task automatic testReset();
    cvtStatus_t st;
    fpWord_u    got;
    checkData("rsp ready/valid", {axilRsp.awready, axilRsp.wready, axilRsp.bvalid,
                                  axilRsp.arready, axilRsp.rvalid}, '0);
    readStatus(st);
    checkStatus("STATUS after reset", st, cvtStatus_t'(2'b00));
    checkFlag("irq", irq, 1'b0);
    for (int e = 0; e < BUF_DEPTH; e++) begin
      readWord(e, got);
      checkWord($sformatf("buffer[%0d]", e), got, fpWord_u'(64'd0));
    end
  endtask

  task automatic testNarrowBasic();
    stim[0] = fpWord_u'(64'h4009_21FB_5444_2D18);
    stim[1] = fpWord_u'(64'hBFB9_9999_9999_999A);
    stim[2] = fpWord_u'(64'h0000_0000_0000_0000);
    stim[3] = fpWord_u'(64'h8000_0000_0000_0000);
    stim[4] = fpWord_u'(64'h7FF0_0000_0000_0000);
    stim[5] = fpWord_u'(64'hFFF0_0000_0000_0000);
    // payload only below the kept bits
    stim[6] = fpWord_u'(64'h7FF0_0000_0000_0001);
    stim[7] = fpWord_u'(64'hFFF4_0000_1234_5678);
    runBatch(1'b0, BUF_DEPTH);
  endtask

  task automatic testNarrowEdge();
    stim[0] = mk64(1'b0, 897, 52'h1);
    stim[1] = mk64(1'b1, 896, '1);
    stim[2] = mk64(1'b0, 1150, '1);
    stim[3] = mk64(1'b1, 1151, '0);
    stim[4] = mk64(1'b0, 0, 52'h1);
    stim[5] = mk64(1'b1, 0, 52'h8_0000_0000_0000);
    stim[6] = mk64(1'b0, 1, '0);
    stim[7] = mk64(1'b1, 2046, 52'h123);
    runBatch(1'b0, BUF_DEPTH);
  endtask

  task automatic testWiden();
    stim[0] = mk32(32'h3F80_0000);
    stim[1] = mk32(32'h8000_0000);
    stim[2] = mk32(32'h7F80_0000);
    stim[3] = mk32(32'hFF80_0000);
    stim[4] = mk32(32'h7F80_0001);
    // subnormals with 22, 0 and 6 leading zeros
    stim[5] = mk32(32'h0000_0001);
    stim[6] = mk32(32'h8040_0000);
    stim[7] = mk32(32'h0001_2345);
    runBatch(1'b1, BUF_DEPTH);
  endtask

  task automatic testRandom();
    for (int m = 0; m < 2; m++) begin
      for (int c = 1; c <= BUF_DEPTH; c++) begin
        for (int e = 0; e < BUF_DEPTH; e++)
          stim[e] = fpWord_u'({$urandom, $urandom});
        runBatch(m[0], c);
      end
    end
  endtask

  task automatic testBusyAndErrors();
    logic [1:0]  resp;
    logic [31:0] data;
    for (int e = 0; e < BUF_DEPTH; e++) begin
      stim[e] = fpWord_u'({$urandom, $urandom});
      writeWord(e, stim[e]);
    end
    writeOk(ADDR_CTRL, {28'd0, 1'b0, 3'd7});
    // both land while the full batch is still running
    axilWrite(ADDR_BUF, 32'hFFFF_FFFF, resp);
    checkResp("bresp buffer write while busy", resp, RESP_SLVERR);
    axilWrite(ADDR_CTRL, {28'd0, 1'b1, 3'd7}, resp);
    checkResp("bresp CTRL write while busy", resp, RESP_SLVERR);
    finishBatch(1'b0, BUF_DEPTH);
    // unmapped and misaligned accesses
    axilRead(8'h08, data, resp);
    checkResp("rresp @08", resp, RESP_SLVERR);
    checkData("rdata @08", data, '0);
    axilRead(8'h3C, data, resp);
    checkResp("rresp @3c", resp, RESP_SLVERR);
    checkData("rdata @3c", data, '0);
    axilRead(8'h42, data, resp);
    checkResp("rresp @42", resp, RESP_SLVERR);
    checkData("rdata @42", data, '0);
    axilWrite(8'h10, 32'h1, resp);
    checkResp("bresp @10", resp, RESP_SLVERR);
  endtask

  // ==============================
  // run
  // ==============================
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    failRun("watchdog expired before the tests finished");
  end

  initial begin
    clk       = 1'b0;
    arstN     = 1'b0;
    axilReq   = '0;
    seedDummy = $urandom(SEED);
    repeat (8) @(posedge clk);
    #1;
    arstN = 1'b1;
    testReset();
    testNarrowBasic();
    testNarrowEdge();
    testWiden();
    testRandom();
    testBusyAndErrors();
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+include
rtl/fpFormatPkg.sv
rtl/fpCvtRegPkg.sv
rtl/fpDecomp.sv
rtl/f64ToF32.sv
rtl/f32ToF64.sv
rtl/fpCvtIndex.sv
rtl/fpCvtSeq.sv
rtl/fpCvtBuffer.sv
rtl/fpCvtAxil.sv
rtl/fpCvtTop.sv
tb/fpCvtTb.sv
